// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 -Wno-fatal
TOP       = tb_u1e_core
FILELIST  = all.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+verilog
verilog/wb_bus_pkg.sv
verilog/core_regs_pkg.sv
verilog/host_bridge.sv
verilog/wb_intercon.sv
verilog/misc_regs.sv
verilog/settings_bus.sv
verilog/loopback_fifo.sv
verilog/u1e_core.sv
sim/tb_u1e_core.sv

// File: sim/tb_u1e_core.sv
`default_nettype none
`include "wb_settings.svh"

module tb_u1e_core;

   import wb_bus_pkg::*;
   import core_regs_pkg::*;

   // About 95 transfers of 6 or 7 cycles each, with five times margin
   localparam int unsigned TIMEOUT_CYCLES = 3000;
   localparam reg_off_t    FIFO_DATA      = 7'd0;
   localparam reg_off_t    FIFO_LEVEL     = 7'd2;
   localparam int          FIFO_DEPTH     = 1 << `FIFO_AW;

   logic       wb_clk, wb_rst;
   logic       host_req_i, host_we_i, host_ack_o;
   wb_adr_t    host_adr_i;
   wb_sel_t    host_sel_i;
   wb_dat_t    host_dat_i, host_dat_o;
   logic [7:0] switches_i;
   logic [2:0] leds_o;
   wb_dat_t    test_o;
   logic       set_stb_o, fifo_overrun_o;
   set_addr_t  set_addr_o;
   set_data_t  set_data_o;

   // Reference model state
   logic [2:0]  m_leds;
   wb_dat_t     m_test;
   logic [7:0]  m_switches;
   wb_dat_t     m_set_low;
   wb_dat_t     m_fifo[$];
   logic        m_overrun;

   wb_dat_t     exp_rd_q[$];    // Expected host read data
   logic [39:0] exp_set_q[$];   // {addr, data} of expected settings pulses
   logic [39:0] set_exp;
   logic        ack_q;
   int unsigned cycles = 0;
   integer      seed;
   wb_dat_t     d;

   u1e_core uut
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .host_req_i(host_req_i), .host_we_i(host_we_i), .host_adr_i(host_adr_i),
      .host_sel_i(host_sel_i), .host_dat_i(host_dat_i),
      .host_ack_o(host_ack_o), .host_dat_o(host_dat_o),
      .switches_i(switches_i), .leds_o(leds_o), .test_o(test_o),
      .set_stb_o(set_stb_o), .set_addr_o(set_addr_o), .set_data_o(set_data_o),
      .fifo_overrun_o(fifo_overrun_o));

   initial
   begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   ////////////////////
   // Failure reporting

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
         abort_run($sformatf("** Error: %s expected 0x%0h, got 0x%0h", name, exp, act));
   endtask

   ////////////////////
   // Reference model

   function automatic wb_adr_t mk_adr(input logic [3:0] dec, input reg_off_t off);
      return {dec, off};
   endfunction

   // Expected read data for the current model state
   function automatic wb_dat_t ref_read(input wb_adr_t adr);
      reg_off_t off;
      wb_dat_t  r;
      off = adr[6:0];
      r   = `BAD_ADDR_DATA;
      case (adr[10:7])
         `DEC_MISC :
            if (off == `REG_LEDS)
               r = {13'd0, m_leds};
            else if (off == `REG_SWITCHES)
               r = {8'd0, m_switches};
            else if (off == `REG_TEST)
               r = m_test;
         `DEC_SET  : r = '0;   // Write only
         `DEC_FIFO :
            if (off == FIFO_DATA)
               r = (m_fifo.size() == 0) ? 16'h0000 : m_fifo[0];
            else if (off == FIFO_LEVEL)
               r = wb_dat_t'(m_fifo.size());
         default   : r = `BAD_ADDR_DATA;
      endcase
      return r;
   endfunction

   function automatic void model_write(input wb_adr_t adr, input wb_dat_t dat);
      reg_off_t off;
      off = adr[6:0];
      case (adr[10:7])
         `DEC_MISC :
            if (off == `REG_LEDS)
               m_leds = dat[2:0];
            else if (off == `REG_TEST)
               m_test = dat;
         `DEC_SET :
            if (!off[1])
               m_set_low = dat;
            else
               exp_set_q.push_back({set_addr_t'(off[6:2]), dat, m_set_low});
         `DEC_FIFO :
            if (off == FIFO_DATA)
            begin
               if (m_fifo.size() < FIFO_DEPTH)
                  m_fifo.push_back(dat);
               else
                  m_overrun = 1'b1;   // Dropped push
            end
         default : ;
      endcase
   endfunction

   ////////////////////
   // Host driver

   task automatic bus_xfer(input logic we, input wb_adr_t adr, input wb_dat_t dat);
      if (we)
         model_write(adr, dat);
      else
      begin
         exp_rd_q.push_back(ref_read(adr));
         if ((adr[10:7] == `DEC_FIFO) && (adr[6:0] == FIFO_DATA) && (m_fifo.size() != 0))
            m_fifo.delete(0);
      end
      @(posedge wb_clk);
      host_req_i <= 1'b1;
      host_we_i  <= we;
      host_adr_i <= adr;
      host_sel_i <= 2'b11;
      host_dat_i <= dat;
      @(posedge wb_clk);
      while (!host_ack_o)
         @(posedge wb_clk);
      host_req_i <= 1'b0;
      @(posedge wb_clk);
      while (host_ack_o)   // Four-phase, wait for ack to drop
         @(posedge wb_clk);
   endtask

   task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat);
      bus_xfer(1'b1, adr, dat);
   endtask

   task automatic bus_read(input wb_adr_t adr);
      bus_xfer(1'b0, adr, '0);
   endtask

   task automatic settings_pair(input logic [4:0] idx);
      wb_dat_t lo;
      wb_dat_t hi;
      lo = wb_dat_t'($random(seed));
      hi = wb_dat_t'($random(seed));
      bus_write(mk_adr(`DEC_SET, {idx, 2'b00}), lo);
      bus_write(mk_adr(`DEC_SET, {idx, 2'b10}), hi);
      if (exp_set_q.size() != 0)
         abort_run("Settings strobe missing after the high half write");
   endtask

   ////////////////////
   // Comparison

   always @(posedge wb_clk)
   begin
      if (!wb_rst)
      begin
         if (host_ack_o && !ack_q && !host_we_i)   // First ack cycle of a read
         begin
            if (exp_rd_q.size() == 0)
               abort_run("Host read data returned with no read pending");
            else
               check("host_dat_o", 32'(exp_rd_q.pop_front()), 32'(host_dat_o));
         end
         if (set_stb_o)
         begin
            if (exp_set_q.size() == 0)
               abort_run("Unexpected set_stb_o pulse");
            else
            begin
               set_exp = exp_set_q.pop_front();
               check("set_addr_o", 32'(set_exp[39:32]), 32'(set_addr_o));
               check("set_data_o", set_exp[31:0], set_data_o);
            end
         end
      end
      ack_q <= host_ack_o;
   end

   always @(posedge wb_clk)
   begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYCLES)
         abort_run("Timeout: the tests did not finish within the cycle limit");
   end

   ////////////////////
   // Stimulus

   initial
   begin
      seed       = 32'hbce3;
      wb_rst     = 1'b1;
      host_req_i = 1'b0;
      host_we_i  = 1'b0;
      host_adr_i = '0;
      host_sel_i = '0;
      host_dat_i = '0;
      switches_i = 8'h00;
      m_leds     = '0;
      m_test     = '0;
      m_switches = '0;
      m_set_low  = '0;
      m_overrun  = 1'b0;
      repeat (3) @(posedge wb_clk);
      wb_rst <= 1'b0;
      @(posedge wb_clk);

      // Reset values
      check("leds_o", 32'(m_leds), 32'(leds_o));
      check("test_o", 32'(m_test), 32'(test_o));
      check("fifo_overrun_o", 32'(m_overrun), 32'(fifo_overrun_o));
      bus_read(mk_adr(`DEC_MISC, `REG_LEDS));

      // Misc registers
      repeat (6)
      begin
         d = wb_dat_t'($random(seed));
         bus_write(mk_adr(`DEC_MISC, `REG_LEDS), d);
         bus_read(mk_adr(`DEC_MISC, `REG_LEDS));
         check("leds_o", 32'(m_leds), 32'(leds_o));
         d = wb_dat_t'($random(seed));
         bus_write(mk_adr(`DEC_MISC, `REG_TEST), d);
         bus_read(mk_adr(`DEC_MISC, `REG_TEST));
         check("test_o", 32'(m_test), 32'(test_o));
      end
      repeat (3)
      begin
         @(posedge wb_clk);
         m_switches = 8'($random(seed));
         switches_i <= m_switches;
         bus_read(mk_adr(`DEC_MISC, `REG_SWITCHES));
      end
      bus_write(mk_adr(`DEC_MISC, `REG_SWITCHES), 16'h00ff);   // Read only
      bus_read(mk_adr(`DEC_MISC, `REG_SWITCHES));
      bus_read(mk_adr(`DEC_MISC, 7'd6));
      bus_read(mk_adr(4'h3, 7'd0));
      bus_read(mk_adr(4'hf, 7'h55));

      // Settings bus
      settings_pair(5'd0);
      settings_pair(5'd5);
      settings_pair(5'd17);
      settings_pair(5'd31);
      bus_read(mk_adr(`DEC_SET, 7'd0));

      // FIFO order and empty pop
      repeat (8)
         bus_write(mk_adr(`DEC_FIFO, FIFO_DATA), wb_dat_t'($random(seed)));
      bus_read(mk_adr(`DEC_FIFO, FIFO_LEVEL));
      repeat (8)
         bus_read(mk_adr(`DEC_FIFO, FIFO_DATA));
      bus_read(mk_adr(`DEC_FIFO, FIFO_DATA));
      check("fifo_overrun_o", 32'(m_overrun), 32'(fifo_overrun_o));

      // Overrun, one push past full
      repeat (FIFO_DEPTH + 1)
         bus_write(mk_adr(`DEC_FIFO, FIFO_DATA), wb_dat_t'($random(seed)));
      bus_read(mk_adr(`DEC_FIFO, FIFO_LEVEL));
      check("fifo_overrun_o", 32'(m_overrun), 32'(fifo_overrun_o));
      repeat (FIFO_DEPTH)
         bus_read(mk_adr(`DEC_FIFO, FIFO_DATA));
      bus_read(mk_adr(`DEC_FIFO, FIFO_LEVEL));

      repeat (4) @(posedge wb_clk);
      if ((exp_rd_q.size() != 0) || (exp_set_q.size() != 0))
         abort_run("Expected responses were left unchecked at the end of the run");
      else
      begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: verilog/core_regs_pkg.sv
`default_nettype none
`include "wb_settings.svh"

package core_regs_pkg;

   // Offset inside one slave window, address bits 6 to 0
   typedef logic [`WB_AW-5:0] reg_off_t;

   // Settings bus register index and word
   typedef logic [7:0]        set_addr_t;
   typedef logic [2*`WB_DW-1:0] set_data_t;

   // Entry count, one bit wider than the pointers so full fits
   typedef logic [`FIFO_AW:0] fifo_level_t;

endpackage

`default_nettype wire

// File: verilog/host_bridge.sv
`default_nettype none
`include "wb_settings.svh"

module host_bridge
  (input  wire                      wb_clk,
   input  wire                      wb_rst,

   // Host side, four-phase req/ack
   input  wire                      host_req_i,
   input  wire                      host_we_i,
   input  wire wb_bus_pkg::wb_adr_t host_adr_i,
   input  wire wb_bus_pkg::wb_sel_t host_sel_i,
   input  wire wb_bus_pkg::wb_dat_t host_dat_i,
   output logic                     host_ack_o,
   output wb_bus_pkg::wb_dat_t      host_dat_o,

   // Wishbone master
   input  wire                      wb_ack_i,
   input  wire wb_bus_pkg::wb_dat_t wb_dat_i,
   output logic                     wb_cyc_o,
   output logic                     wb_stb_o,
   output logic                     wb_we_o,
   output wb_bus_pkg::wb_adr_t      wb_adr_o,
   output wb_bus_pkg::wb_sel_t      wb_sel_o,
   output wb_bus_pkg::wb_dat_t      wb_dat_o
   );

   import wb_bus_pkg::*;

   host_state_t state;

   ////////////////////
   // Control FSM

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         state      <= ST_IDLE;
         wb_cyc_o   <= 1'b0;
         wb_stb_o   <= 1'b0;
         host_ack_o <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE :
               if (host_req_i)
               begin
                  state    <= ST_BUS;
                  wb_cyc_o <= 1'b1;
                  wb_stb_o <= 1'b1;
               end
            ST_BUS :
               if (wb_ack_i)   // Single cycle only, end it now
               begin
                  state      <= ST_ACK;
                  wb_cyc_o   <= 1'b0;
                  wb_stb_o   <= 1'b0;
                  host_ack_o <= 1'b1;
               end
            ST_ACK, ST_WAIT_DROP :
               if (!host_req_i)
               begin
                  state      <= ST_IDLE;
                  host_ack_o <= 1'b0;
               end
               else
                  state <= ST_WAIT_DROP;
            default :
               state <= ST_IDLE;
         endcase
      end
   end

   // Request and response payload
   always_ff @(posedge wb_clk)
   begin
      if ((state == ST_IDLE) && host_req_i)
      begin
         wb_we_o  <= host_we_i;
         wb_adr_o <= host_adr_i;
         wb_sel_o <= host_sel_i;
         wb_dat_o <= host_dat_i;
      end
      if ((state == ST_BUS) && wb_ack_i)
         host_dat_o <= wb_dat_i;   // Read data held through host ack
   end

   ////////////////////
   // Checks

   // Slaves only answer a live strobe
   a_ack_in_cycle : assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_ack_i |-> (wb_cyc_o && wb_stb_o));

   // Ack must answer a live request
   a_ack_needs_req : assert property (@(posedge wb_clk) disable iff (wb_rst)
      $rose(host_ack_o) |-> host_req_i);

endmodule

`default_nettype wire

// File: verilog/loopback_fifo.sv
`default_nettype none
`include "wb_settings.svh"

module loopback_fifo
  (input  wire                          wb_clk,
   input  wire                          wb_rst,

   // Slave port
   input  wire                          cyc_i,
   input  wire                          stb_i,
   input  wire                          we_i,
   input  wire core_regs_pkg::reg_off_t off_i,
   input  wire wb_bus_pkg::wb_dat_t     dat_i,
   output logic                         ack_o,
   output wb_bus_pkg::wb_dat_t          dat_o,

   output logic                         fifo_overrun_o
   );

   import wb_bus_pkg::*;
   import core_regs_pkg::*;

   localparam reg_off_t    OFF_DATA  = 7'd0;   // push / pop
   localparam reg_off_t    OFF_LEVEL = 7'd2;   // read only
   localparam fifo_level_t DEPTH     = fifo_level_t'(1 << `FIFO_AW);

   wb_dat_t             mem [0:(1 << `FIFO_AW)-1];
   logic [`FIFO_AW-1:0] wr_ptr, rd_ptr;
   fifo_level_t         level;
   logic                access, empty, full, push, pop;

   // Only act on the first stb cycle
   assign access = cyc_i & stb_i & ~ack_o;
   assign empty  = (level == '0);
   assign full   = (level == DEPTH);
   assign push   = access & we_i & (off_i == OFF_DATA) & ~full;
   assign pop    = access & ~we_i & (off_i == OFF_DATA) & ~empty;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         ack_o          <= 1'b0;
         wr_ptr         <= '0;
         rd_ptr         <= '0;
         level          <= '0;
         fifo_overrun_o <= 1'b0;
      end
      else
      begin
         ack_o <= access;
         if (push)
         begin
            wr_ptr <= wr_ptr + 1'b1;
            level  <= level + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
            level  <= level - 1'b1;
         end
         if (access && we_i && (off_i == OFF_DATA) && full)
            fifo_overrun_o <= 1'b1;   // Sticky until reset
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (push)
         mem[wr_ptr] <= dat_i;
      if (access && !we_i)
      begin
         case (off_i)
            OFF_DATA  : dat_o <= empty ? '0 : mem[rd_ptr];
            OFF_LEVEL : dat_o <= wb_dat_t'(level);
            default   : dat_o <= `BAD_ADDR_DATA;
         endcase
      end
   end

   a_level_bound : assert property (@(posedge wb_clk) disable iff (wb_rst)
      level <= DEPTH);

endmodule

`default_nettype wire

// File: verilog/misc_regs.sv
`default_nettype none
`include "wb_settings.svh"

module misc_regs
  (input  wire                          wb_clk,
   input  wire                          wb_rst,

   // Slave port
   input  wire                          cyc_i,
   input  wire                          stb_i,
   input  wire                          we_i,
   input  wire core_regs_pkg::reg_off_t off_i,
   input  wire wb_bus_pkg::wb_dat_t     dat_i,
   output wire                          ack_o,
   output wb_bus_pkg::wb_dat_t          dat_o,

   // Board
   input  wire [7:0]                    switches_i,
   output wire [2:0]                    leds_o,
   output wire wb_bus_pkg::wb_dat_t     test_o
   );

   import wb_bus_pkg::*;

   logic [2:0] leds_r;
   wb_dat_t    test_r;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         leds_r <= 3'd0;
         test_r <= '0;
      end
      else if (cyc_i && stb_i && we_i)
      begin
         case (off_i)
            `REG_LEDS : leds_r <= dat_i[2:0];
            `REG_TEST : test_r <= dat_i;
            default   : ;   // Switches and holes are read only
         endcase
      end
   end

   assign leds_o = leds_r;
   assign test_o = test_r;

   // Readback
   always_comb
   begin
      case (off_i)
         `REG_LEDS     : dat_o = wb_dat_t'(leds_r);
         `REG_SWITCHES : dat_o = wb_dat_t'(switches_i);
         `REG_TEST     : dat_o = test_r;
         default       : dat_o = `BAD_ADDR_DATA;
      endcase
   end

   assign ack_o = cyc_i & stb_i;   // Same cycle

endmodule

`default_nettype wire

// File: verilog/settings_bus.sv
`default_nettype none
`include "wb_settings.svh"

module settings_bus
  (input  wire                          wb_clk,
   input  wire                          wb_rst,

   // Slave port
   input  wire                          cyc_i,
   input  wire                          stb_i,
   input  wire                          we_i,
   input  wire core_regs_pkg::reg_off_t off_i,
   input  wire wb_bus_pkg::wb_dat_t     dat_i,
   output wire                          ack_o,
   output wire wb_bus_pkg::wb_dat_t     dat_o,

   // Settings out
   output logic                         set_stb_o,
   output core_regs_pkg::set_addr_t     set_addr_o,
   output core_regs_pkg::set_data_t     set_data_o
   );

   import wb_bus_pkg::*;
   import core_regs_pkg::*;

   wb_dat_t low_r;
   logic    wr;

   assign wr = cyc_i & stb_i & we_i;

   // Low half waits here for its partner
   always_ff @(posedge wb_clk)
   begin
      if (wr && !off_i[1])
         low_r <= dat_i;
      if (wr && off_i[1])
      begin
         set_addr_o <= set_addr_t'(off_i[6:2]);
         set_data_o <= {dat_i, low_r};
      end
   end

   // One cycle strobe per high write
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr & off_i[1];
   end

   assign ack_o = cyc_i & stb_i;
   assign dat_o = '0;   // Write only

endmodule

`default_nettype wire

// File: verilog/u1e_core.sv
`default_nettype none
`include "wb_settings.svh"

module u1e_core
  (input  wire                          wb_clk,
   input  wire                          wb_rst,

   // Host port
   input  wire                          host_req_i,
   input  wire                          host_we_i,
   input  wire wb_bus_pkg::wb_adr_t     host_adr_i,
   input  wire wb_bus_pkg::wb_sel_t     host_sel_i,
   input  wire wb_bus_pkg::wb_dat_t     host_dat_i,
   output wire                          host_ack_o,
   output wire wb_bus_pkg::wb_dat_t     host_dat_o,

   // Board and settings
   input  wire [7:0]                    switches_i,
   output wire [2:0]                    leds_o,
   output wire wb_bus_pkg::wb_dat_t     test_o,
   output wire                          set_stb_o,
   output wire core_regs_pkg::set_addr_t set_addr_o,
   output wire core_regs_pkg::set_data_t set_data_o,
   output wire                          fifo_overrun_o
   );

   import wb_bus_pkg::*;
   import core_regs_pkg::*;

   wire      m_cyc, m_stb, m_we, m_ack;
   wire      wb_adr_t m_adr;
   wire      wb_dat_t m_dat_mosi, m_dat_miso;
   wire      s_cyc, s_we;
   wire      reg_off_t s_off;
   wire      wb_dat_t s_dat_mosi;
   wire      s0_stb, s1_stb, s2_stb, s0_ack, s1_ack, s2_ack;
   wire      wb_dat_t s0_dat_miso, s1_dat_miso, s2_dat_miso;

   ////////////////////
   // Host to Wishbone master
   host_bridge bridge
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .host_req_i(host_req_i), .host_we_i(host_we_i), .host_adr_i(host_adr_i),
      .host_sel_i(host_sel_i), .host_dat_i(host_dat_i),
      .host_ack_o(host_ack_o), .host_dat_o(host_dat_o),
      .wb_ack_i(m_ack), .wb_dat_i(m_dat_miso),
      .wb_cyc_o(m_cyc), .wb_stb_o(m_stb), .wb_we_o(m_we), .wb_adr_o(m_adr),
      .wb_sel_o(),   // No slave uses byte selects
      .wb_dat_o(m_dat_mosi));

   ////////////////////
   // Intercon, single master
   wb_intercon intercon
     (.m_cyc_i(m_cyc), .m_stb_i(m_stb), .m_we_i(m_we), .m_adr_i(m_adr),
      .m_dat_i(m_dat_mosi), .m_ack_o(m_ack), .m_dat_o(m_dat_miso),
      .s_cyc_o(s_cyc), .s_we_o(s_we), .s_off_o(s_off), .s_dat_o(s_dat_mosi),
      .s0_stb_o(s0_stb), .s1_stb_o(s1_stb), .s2_stb_o(s2_stb),
      .s0_ack_i(s0_ack), .s1_ack_i(s1_ack), .s2_ack_i(s2_ack),
      .s0_dat_i(s0_dat_miso), .s1_dat_i(s1_dat_miso), .s2_dat_i(s2_dat_miso));

   ////////////////////
   // Slave 0, misc registers
   misc_regs misc
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .cyc_i(s_cyc), .stb_i(s0_stb), .we_i(s_we), .off_i(s_off), .dat_i(s_dat_mosi),
      .ack_o(s0_ack), .dat_o(s0_dat_miso),
      .switches_i(switches_i), .leds_o(leds_o), .test_o(test_o));

   // Slave 1, settings bus
   settings_bus settings
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .cyc_i(s_cyc), .stb_i(s1_stb), .we_i(s_we), .off_i(s_off), .dat_i(s_dat_mosi),
      .ack_o(s1_ack), .dat_o(s1_dat_miso),
      .set_stb_o(set_stb_o), .set_addr_o(set_addr_o), .set_data_o(set_data_o));

   // Slave 2, loopback FIFO
   loopback_fifo fifo
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .cyc_i(s_cyc), .stb_i(s2_stb), .we_i(s_we), .off_i(s_off), .dat_i(s_dat_mosi),
      .ack_o(s2_ack), .dat_o(s2_dat_miso),
      .fifo_overrun_o(fifo_overrun_o));

endmodule

`default_nettype wire

// File: verilog/wb_bus_pkg.sv
`default_nettype none
`include "wb_settings.svh"

package wb_bus_pkg;

   typedef logic [`WB_DW-1:0] wb_dat_t;
   typedef logic [`WB_AW-1:0] wb_adr_t;
   typedef logic [`WB_SW-1:0] wb_sel_t;   // Carried only, slaves ignore it

   // Target of the current bus cycle
   typedef enum logic [1:0] {SLV_MISC, SLV_SET, SLV_FIFO, SLV_NONE} slave_id_t;

   // Bridge FSM
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_BUS,         // Wishbone cycle in flight
      ST_ACK,         // First cycle of host ack
      ST_WAIT_DROP    // Host still holding req
   } host_state_t;

endpackage

`default_nettype wire

// File: verilog/wb_intercon.sv
`default_nettype none
`include "wb_settings.svh"

module wb_intercon
  (// Master side
   input  wire                         m_cyc_i,
   input  wire                         m_stb_i,
   input  wire                         m_we_i,
   input  wire wb_bus_pkg::wb_adr_t    m_adr_i,
   input  wire wb_bus_pkg::wb_dat_t    m_dat_i,
   output logic                        m_ack_o,
   output wb_bus_pkg::wb_dat_t         m_dat_o,

   // Shared to all slaves
   output wire                         s_cyc_o,
   output wire                         s_we_o,
   output wire core_regs_pkg::reg_off_t s_off_o,
   output wire wb_bus_pkg::wb_dat_t    s_dat_o,

   // Per slave
   output logic                        s0_stb_o,
   output logic                        s1_stb_o,
   output logic                        s2_stb_o,
   input  wire                         s0_ack_i,
   input  wire                         s1_ack_i,
   input  wire                         s2_ack_i,
   input  wire wb_bus_pkg::wb_dat_t    s0_dat_i,
   input  wire wb_bus_pkg::wb_dat_t    s1_dat_i,
   input  wire wb_bus_pkg::wb_dat_t    s2_dat_i
   );

   import wb_bus_pkg::*;

   slave_id_t sid;

   assign s_cyc_o = m_cyc_i;
   assign s_we_o  = m_we_i;
   assign s_off_o = m_adr_i[`WB_AW-5:0];
   assign s_dat_o = m_dat_i;

   always_comb
   begin
      case (m_adr_i[`WB_AW-1:`WB_AW-4])   // Top four bits pick the slave
         `DEC_MISC : sid = SLV_MISC;
         `DEC_SET  : sid = SLV_SET;
         `DEC_FIFO : sid = SLV_FIFO;
         default   : sid = SLV_NONE;
      endcase
   end

   // Strobe fan-out
   always_comb
   begin
      s0_stb_o = m_cyc_i && m_stb_i && (sid == SLV_MISC);
      s1_stb_o = m_cyc_i && m_stb_i && (sid == SLV_SET);
      s2_stb_o = m_cyc_i && m_stb_i && (sid == SLV_FIFO);
   end

   // Return path, unmapped space answers by itself
   always_comb
   begin
      case (sid)
         SLV_MISC : m_ack_o = s0_ack_i;
         SLV_SET  : m_ack_o = s1_ack_i;
         SLV_FIFO : m_ack_o = s2_ack_i;
         default  : m_ack_o = m_cyc_i & m_stb_i;
      endcase
      case (sid)
         SLV_MISC : m_dat_o = s0_dat_i;
         SLV_SET  : m_dat_o = s1_dat_i;
         SLV_FIFO : m_dat_o = s2_dat_i;
         default  : m_dat_o = `BAD_ADDR_DATA;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/wb_settings.svh
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Bus widths
`define WB_DW 16
`define WB_AW 11
`define WB_SW 2

// Slave decode values in address bits 10 to 7
`define DEC_MISC 4'h0
`define DEC_SET  4'h1
`define DEC_FIFO 4'h2

// Misc register offsets in address bits 6 to 0
`define REG_LEDS     7'd0   // out
`define REG_SWITCHES 7'd2   // in
`define REG_TEST     7'd4   // out

// Loopback FIFO
`define FIFO_AW 4           // 16 entries

// Returned by unmapped addresses and unknown misc offsets
`define BAD_ADDR_DATA 16'hBEEF

`endif
